//--- hw/ppu_pkg.sv
package ppu_pkg;

	// --------------------
	// cpu register map
	// --------------------
	localparam logic [7:0] REG_LCDC = 8'h40;
	localparam logic [7:0] REG_STAT = 8'h41;
	localparam logic [7:0] REG_SCY  = 8'h42;
	localparam logic [7:0] REG_SCX  = 8'h43;
	localparam logic [7:0] REG_LY   = 8'h44;
	localparam logic [7:0] REG_LYC  = 8'h45;
	localparam logic [7:0] REG_BGP  = 8'h47;

	// stat mode field encodings
	localparam logic [1:0] MODE_HBLANK = 2'd0;
	localparam logic [1:0] MODE_VBLANK = 2'd1;
	localparam logic [1:0] MODE_OAM    = 2'd2;
	localparam logic [1:0] MODE_DRAW   = 2'd3;

	// mode 2 length in dots
	localparam int OAM_DOTS = 80;
	// visible area
	localparam int SCREEN_W = 160;
	localparam int SCREEN_H = 144;

	// --------------------
	// bundles
	// --------------------

	// one cpu register access
	typedef struct packed {
		logic       sel;
		logic       wr;
		logic [7:0] addr;
		logic [7:0] di;
	} cpu_bus_t;

	// register contents needed by the drawing side
	typedef struct packed {
		logic       lcd_on;
		logic       bg_map_sel;
		logic       tile_data_sel;
		logic       bg_ena;
		// stat enables, bits 6..3 of STAT
		logic       ie_lyc;
		logic       ie_oam;
		logic       ie_vbl;
		logic       ie_hbl;
		logic [7:0] scy;
		logic [7:0] scx;
		logic [7:0] lyc;
		logic [7:0] bgp;
	} ppu_ctrl_t;

	// dot timing state
	typedef struct packed {
		logic [7:0] ly;
		logic [1:0] mode;
		logic       line_start;
		logic       draw;
		logic       vblank;
		logic       lyc_match_l;
	} ppu_timing_t;

	// one background pixel
	typedef struct packed {
		logic       valid;
		logic [1:0] pix;
	} bg_pixel_t;

	// vram address seen as a tile map entry
	typedef struct packed {
		logic [1:0] base;
		logic       map_sel;
		logic [4:0] row;
		logic [4:0] col;
	} vram_map_t;

	// vram address seen as one byte of tile data
	typedef struct packed {
		logic       a12;
		logic [7:0] tile;
		logic [2:0] line;
		logic       plane;
	} vram_data_t;

	typedef union packed {
		vram_map_t  map;
		vram_data_t data;
	} vram_addr_u;

endpackage

//--- hw/ppu_reg_file.sv
`timescale 1ns/10ps

module ppu_reg_file
	import ppu_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  cpu_bus_t    cpu,
	input  ppu_timing_t timing,
	output ppu_ctrl_t   ctrl,
	output logic [7:0]  cpu_do
);

	// --------------------
	// stored registers
	// --------------------
	logic [7:0] lcdc;
	// STAT enables {lyc, oam, vblank, hblank}
	logic [3:0] stat_ie;
	logic [7:0] scy;
	logic [7:0] scx;
	logic [7:0] lyc;
	logic [7:0] bgp;

	logic cpu_write;

	assign cpu_write = cpu.sel & cpu.wr;

	// lcd stays off after reset so vram is free for the cpu
	always_ff @(posedge clk) begin
		if (reset) begin
			lcdc    <= 8'h00;
			stat_ie <= 4'h0;
			scy     <= 8'h00;
			scx     <= 8'h00;
			lyc     <= 8'h00;
			bgp     <= 8'hfc;
		end else if (cpu_write) begin
			case (cpu.addr)
				REG_LCDC: lcdc    <= cpu.di;
				// low bits of STAT are status only
				REG_STAT: stat_ie <= cpu.di[6:3];
				REG_SCY:  scy     <= cpu.di;
				REG_SCX:  scx     <= cpu.di;
				REG_LYC:  lyc     <= cpu.di;
				REG_BGP:  bgp     <= cpu.di;
				// LY is read only
				default: ;
			endcase
		end
	end

	// --------------------
	// fields for the drawing side
	// --------------------
	always_comb begin
		ctrl.lcd_on        = lcdc[7];
		ctrl.tile_data_sel = lcdc[4];
		ctrl.bg_map_sel    = lcdc[3];
		ctrl.bg_ena        = lcdc[0];
		ctrl.ie_lyc        = stat_ie[3];
		ctrl.ie_oam        = stat_ie[2];
		ctrl.ie_vbl        = stat_ie[1];
		ctrl.ie_hbl        = stat_ie[0];
		ctrl.scy           = scy;
		ctrl.scx           = scx;
		ctrl.lyc           = lyc;
		ctrl.bgp           = bgp;
	end

	// --------------------
	// read mux
	// --------------------
	// same-cycle read, decoded on address only
	always_comb begin
		case (cpu.addr)
			REG_LCDC: cpu_do = lcdc;
			// bit 7 always reads back as one
			REG_STAT: cpu_do = {1'b1, stat_ie, timing.lyc_match_l, timing.mode};
			REG_SCY:  cpu_do = scy;
			REG_SCX:  cpu_do = scx;
			// live line counter
			REG_LY:   cpu_do = timing.ly;
			REG_LYC:  cpu_do = lyc;
			REG_BGP:  cpu_do = bgp;
			// obp, window and dma addresses are not implemented
			default:  cpu_do = 8'hff;
		endcase
	end

endmodule

//--- hw/ppu_dot_timing.sv
`timescale 1ns/10ps

module ppu_dot_timing
	import ppu_pkg::*;
#(
	parameter int DOTS_PER_LINE   = 456,
	parameter int LINES_PER_FRAME = 154
) (
	input  logic        clk,
	input  logic        reset,
	input  ppu_ctrl_t   ctrl,
	input  logic        draw_done,
	output ppu_timing_t timing,
	output logic        irq,
	output logic        vblank_irq,
	output logic        lcd_vsync
);

	localparam int DW = $clog2(DOTS_PER_LINE);

	logic [DW-1:0] h_cnt;
	logic [7:0]    v_cnt;
	logic          h_last;
	logic          vblank;
	logic          draw_r;
	logic          draw_done_d;
	logic          lyc_match_l;
	logic          line_start;
	logic          vsync_r;

	// last dot of the line
	assign h_last = (h_cnt == DW'(DOTS_PER_LINE - 1));
	assign vblank = (v_cnt >= 8'(SCREEN_H));

	// --------------------
	// dot and line counters
	// --------------------
	always_ff @(posedge clk) begin
		if (reset || !ctrl.lcd_on) begin
			h_cnt   <= '0;
			v_cnt   <= 8'd0;
			vsync_r <= 1'b0;
		end else begin
			h_cnt <= h_last ? '0 : h_cnt + 1'b1;
			if (h_last) begin
				if (v_cnt == 8'(LINES_PER_FRAME - 1))
					v_cnt <= 8'd0;
				else
					v_cnt <= v_cnt + 8'd1;
				// high for the whole of line 0, not on the first frame after enable
				vsync_r <= (v_cnt == 8'(LINES_PER_FRAME - 1));
			end
		end
	end

	// --------------------
	// mode 3 window
	// --------------------
	// opens right after mode 2, closes the cycle after the last pixel
	// so the delayed lcd strobe still falls inside mode 3
	always_ff @(posedge clk) begin
		if (reset || !ctrl.lcd_on) begin
			draw_r      <= 1'b0;
			draw_done_d <= 1'b0;
		end else begin
			draw_done_d <= draw_done;
			if (draw_done_d)
				draw_r <= 1'b0;
			else if (!vblank && h_cnt == DW'(OAM_DOTS - 1))
				draw_r <= 1'b1;
		end
	end

	// coincidence flag sampled once a line, a few dots in
	always_ff @(posedge clk) begin
		if (reset || !ctrl.lcd_on)
			lyc_match_l <= 1'b0;
		else if (h_cnt == DW'(3))
			lyc_match_l <= (v_cnt == ctrl.lyc);
	end

	assign line_start = ctrl.lcd_on & !vblank & (h_cnt == '0);

	// --------------------
	// status out
	// --------------------
	always_comb begin
		timing.ly          = v_cnt;
		timing.line_start  = line_start;
		timing.draw        = draw_r & ctrl.lcd_on;
		timing.vblank      = vblank;
		timing.lyc_match_l = lyc_match_l;
		if (!ctrl.lcd_on)
			timing.mode = MODE_HBLANK;
		else if (vblank)
			timing.mode = MODE_VBLANK;
		else if (draw_r)
			timing.mode = MODE_DRAW;
		else if (h_cnt < DW'(OAM_DOTS))
			timing.mode = MODE_OAM;
		else
			timing.mode = MODE_HBLANK;
	end

	// stat interrupt, plain OR of the enabled sources
	assign irq = (ctrl.ie_lyc & lyc_match_l)
		| (ctrl.ie_oam & line_start)
		| (ctrl.ie_vbl & vblank)
		| (ctrl.ie_hbl & draw_done);

	assign vblank_irq = vblank;
	assign lcd_vsync  = vsync_r;

endmodule

//--- hw/ppu_bg_fetcher.sv
`timescale 1ns/10ps

module ppu_bg_fetcher
	import ppu_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  ppu_ctrl_t   ctrl,
	input  ppu_timing_t timing,
	output logic        vram_rd,
	output vram_addr_u  vram_addr,
	input  logic [7:0]  vram_data,
	output bg_pixel_t   pixel,
	output logic        draw_done
);

	// counts 0..7 feed the first, discarded tile
	localparam logic [7:0] PIX_FIRST = 8'd8;
	localparam logic [7:0] PIX_LAST  = 8'(8 + SCREEN_W - 1);

	// fetch step, 0-1 map, 2-3 low plane, 4-5 high plane
	logic [2:0] fetch_cycle;
	logic [4:0] fetch_num;
	logic [3:0] shift_cnt;
	logic [7:0] pcnt;
	logic [7:0] tile_num;
	logic [7:0] plane_lo;
	logic [7:0] shift_lo;
	logic [7:0] shift_hi;
	logic [7:0] bg_line;
	logic [4:0] map_col;
	logic       shifting;
	logic       reload;

	// line inside the 256x256 background
	assign bg_line = timing.ly + ctrl.scy;
	// fine scroll is ignored, first fetch is one tile left of scx
	assign map_col = ctrl.scx[7:3] + fetch_num - 5'd1;

	assign shifting = (shift_cnt != 4'd0);
	// last pixel of the current tile goes out while the next one loads
	assign reload = timing.draw & (fetch_cycle == 3'd5) & (shift_cnt <= 4'd1);

	// --------------------
	// fetch sequencer
	// --------------------
	always_ff @(posedge clk) begin
		if (reset || !timing.draw) begin
			fetch_cycle <= 3'd0;
			fetch_num   <= 5'd0;
			shift_cnt   <= 4'd0;
			pcnt        <= 8'd0;
		end else begin
			// wait in step 5 until the shifter runs dry
			if (fetch_cycle != 3'd5)
				fetch_cycle <= fetch_cycle + 3'd1;
			if (shifting) begin
				shift_cnt <= shift_cnt - 4'd1;
				pcnt      <= pcnt + 8'd1;
			end
			if (reload) begin
				fetch_cycle <= 3'd0;
				fetch_num   <= fetch_num + 5'd1;
				shift_cnt   <= 4'd8;
			end
		end
	end

	// data latches and the pixel shifter
	always_ff @(posedge clk) begin
		if (timing.draw && fetch_cycle == 3'd1)
			tile_num <= vram_data;
		if (timing.draw && fetch_cycle == 3'd3)
			plane_lo <= vram_data;
		if (reload) begin
			shift_lo <= plane_lo;
			// high plane is taken straight off the bus in step 5
			shift_hi <= vram_data;
		end else if (shifting) begin
			shift_lo <= shift_lo << 1;
			shift_hi <= shift_hi << 1;
		end
	end

	// --------------------
	// vram address
	// --------------------
	always_comb begin
		vram_addr = '0;
		if (fetch_cycle < 3'd2) begin
			// map entries live at 1800h or 1c00h
			vram_addr.map.base    = 2'b11;
			vram_addr.map.map_sel = ctrl.bg_map_sel;
			vram_addr.map.row     = bg_line[7:3];
			vram_addr.map.col     = map_col;
		end else begin
			// signed tile numbers when tile_data_sel is clear
			vram_addr.data.a12   = ~ctrl.tile_data_sel & ~tile_num[7];
			vram_addr.data.tile  = tile_num;
			vram_addr.data.line  = bg_line[2:0];
			vram_addr.data.plane = fetch_cycle[2];
		end
	end

	assign vram_rd = timing.draw & ctrl.lcd_on;

	// --------------------
	// pixel out
	// --------------------
	assign pixel.pix   = {shift_hi[7], shift_lo[7]};
	assign pixel.valid = timing.draw & shifting & (pcnt >= PIX_FIRST) & (pcnt <= PIX_LAST);
	assign draw_done   = timing.draw & shifting & (pcnt == PIX_LAST);

endmodule

//--- hw/ppu_lcd_out.sv
`timescale 1ns/10ps

module ppu_lcd_out
	import ppu_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  ppu_ctrl_t  ctrl,
	input  bg_pixel_t  pixel,
	output logic       lcd_clkena,
	output logic [1:0] lcd_data,
	output logic       lcd_on
);

	logic [1:0] color_idx;
	logic [1:0] shade;
	logic       clkena_r;
	logic [1:0] data_r;

	// bg disabled draws color 0
	assign color_idx = ctrl.bg_ena ? pixel.pix : 2'b00;
	// BGP holds two bits per color index
	assign shade = ctrl.bgp[{color_idx, 1'b0} +: 2];

	always_ff @(posedge clk) begin
		if (reset || !ctrl.lcd_on) begin
			clkena_r <= 1'b0;
			data_r   <= 2'b00;
		end else begin
			clkena_r <= pixel.valid;
			// data only moves together with the strobe
			if (pixel.valid)
				data_r <= shade;
		end
	end

	// blank right away when the lcd is switched off
	assign lcd_clkena = clkena_r & ctrl.lcd_on;
	assign lcd_data   = ctrl.lcd_on ? data_r : 2'b00;
	assign lcd_on     = ctrl.lcd_on;

endmodule

//--- hw/ppu_top.sv
`timescale 1ns/10ps

module ppu_top
	import ppu_pkg::*;
#(
	parameter int DOTS_PER_LINE   = 456,
	parameter int LINES_PER_FRAME = 154
) (
	input  logic        clk,
	input  logic        reset,
	// cpu register port
	input  cpu_bus_t    cpu,
	output logic [7:0]  cpu_do,
	// vram read port
	output logic        vram_rd,
	output logic [12:0] vram_addr,
	input  logic [7:0]  vram_data,
	// lcd
	output logic        lcd_on,
	output logic        lcd_clkena,
	output logic [1:0]  lcd_data,
	output logic        lcd_vsync,
	// interrupts
	output logic        irq,
	output logic        vblank_irq
);

	ppu_ctrl_t   ctrl;
	ppu_timing_t timing;
	bg_pixel_t   pixel;
	logic        draw_done;

	// --------------------
	// register decode
	// --------------------
	ppu_reg_file i_ppu_reg_file (
		.clk    (clk),
		.reset  (reset),
		.cpu    (cpu),
		.timing (timing),
		.ctrl   (ctrl),
		.cpu_do (cpu_do)
	);

	// --------------------
	// execution
	// --------------------
	ppu_dot_timing #(
		.DOTS_PER_LINE   (DOTS_PER_LINE),
		.LINES_PER_FRAME (LINES_PER_FRAME)
	) i_ppu_dot_timing (
		.clk        (clk),
		.reset      (reset),
		.ctrl       (ctrl),
		.draw_done  (draw_done),
		.timing     (timing),
		.irq        (irq),
		.vblank_irq (vblank_irq),
		.lcd_vsync  (lcd_vsync)
	);

	// vram address leaves as a plain 13-bit word
	ppu_bg_fetcher i_ppu_bg_fetcher (
		.clk       (clk),
		.reset     (reset),
		.ctrl      (ctrl),
		.timing    (timing),
		.vram_rd   (vram_rd),
		.vram_addr (vram_addr),
		.vram_data (vram_data),
		.pixel     (pixel),
		.draw_done (draw_done)
	);

	// --------------------
	// result
	// --------------------
	ppu_lcd_out i_ppu_lcd_out (
		.clk        (clk),
		.reset      (reset),
		.ctrl       (ctrl),
		.pixel      (pixel),
		.lcd_clkena (lcd_clkena),
		.lcd_data   (lcd_data),
		.lcd_on     (lcd_on)
	);

endmodule

//--- sim/ppu_chk.sv
`timescale 1ns/10ps

module ppu_chk
	import ppu_pkg::*;
(
	input logic       clk,
	input logic       reset,
	input logic       lcd_on,
	input logic       lcd_clkena,
	input logic       vram_rd,
	input logic       vblank_irq,
	input logic [1:0] mode
);

	// pixel strobes only while drawing
	a_strobe_in_draw: assert property (@(posedge clk) disable iff (reset)
		lcd_clkena |-> mode == MODE_DRAW)
		else $error("lcd_clkena high outside mode 3");

	// no vram traffic with the panel off
	a_no_read_when_off: assert property (@(posedge clk) disable iff (reset)
		!lcd_on |-> !vram_rd)
		else $error("vram_rd high while the lcd is off");

	a_no_draw_in_vblank: assert property (@(posedge clk) disable iff (reset)
		vblank_irq |-> mode != MODE_DRAW)
		else $error("mode 3 during vblank");

endmodule

bind ppu_top ppu_chk i_ppu_chk (
	.clk        (clk),
	.reset      (reset),
	.lcd_on     (lcd_on),
	.lcd_clkena (lcd_clkena),
	.vram_rd    (vram_rd),
	.vblank_irq (vblank_irq),
	.mode       (timing.mode)
);

//--- sim/ppu_tb.sv
`timescale 1ns/10ps

module ppu_tb
	import ppu_pkg::*;
();

	localparam int DOTS = 456;
	localparam int LINES = 154;
	localparam int FRAME_CYCLES = DOTS * LINES;
	// three enables of about two frames each, four watched frames, off phase
	localparam int RUN_FRAMES = 10;
	localparam int TIMEOUT_CYCLES = (RUN_FRAMES + 2) * FRAME_CYCLES;
	// what a watch pass looks at
	localparam int WATCH_MODE = 0;
	localparam int WATCH_LYC = 1;
	localparam int WATCH_VBL = 2;
	localparam int WATCH_HBL = 3;
	localparam int WATCH_OFF = 4;
	localparam logic [7:0] RW_REGS [4] = '{REG_SCY, REG_SCX, REG_LYC, REG_BGP};

	logic        clk;
	logic        reset;
	cpu_bus_t    cpu;
	logic [7:0]  cpu_do;
	logic        vram_rd;
	logic [12:0] vram_addr;
	logic [7:0]  vram_data;
	logic        lcd_on;
	logic        lcd_clkena;
	logic [1:0]  lcd_data;
	logic        lcd_vsync;
	logic        irq;
	logic        vblank_irq;

	logic [7:0] vram [0:8191];
	// copies of what the cpu wrote
	logic [7:0] sh_lcdc;
	logic [7:0] sh_scy;
	logic [7:0] sh_scx;
	logic [7:0] sh_lyc;
	logic [7:0] sh_bgp;
	// frame position, rebuilt from lcd_vsync
	int   trk_on = 0;
	int   trk_dot = 0;
	int   trk_line = 0;
	int   trk_pulses = 0;
	int   frames_done = 0;
	int   cycles = 0;
	logic vsync_q = 1'b0;

	ppu_top #(
		.DOTS_PER_LINE   (DOTS),
		.LINES_PER_FRAME (LINES)
	) i_ppu_top (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// vram model, sampled at the falling edge so data is valid in the second address cycle
	always @(negedge clk)
		vram_data <= vram[vram_addr];

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Result: FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			$display("Result: FAILED");
			$fatal(1, "check failed");
		end
	endtask

	// --------------------
	// reference model
	// --------------------
	function automatic logic [1:0] ref_pixel(input int ly, input int x, input logic [7:0] scx,
			input logic [7:0] scy, input logic [7:0] lcdc, input logic [7:0] bgp,
			input logic [7:0] mem [0:8191]);
		logic [7:0]  y;
		logic [12:0] map_a;
		logic [7:0]  tile;
		logic [12:0] data_a;
		logic [1:0]  c;
		y = 8'(ly) + scy;
		// scx[2:0] plays no part, columns start on a tile edge
		map_a = {2'b11, lcdc[3], y[7:3], 5'(x / 8) + scx[7:3]};
		tile = mem[map_a];
		// 8800h mode puts tiles 0..127 at 9000h
		data_a = {~lcdc[4] & ~tile[7], tile, y[2:0], 1'b0};
		c = {mem[data_a | 13'd1][7 - x % 8], mem[data_a][7 - x % 8]};
		if (!lcdc[0])
			c = 2'b00;
		return bgp[2 * c +: 2];
	endfunction

	function automatic logic [1:0] next_mode(input logic [1:0] prev, input logic vbl);
		case (prev)
			MODE_OAM:    return MODE_DRAW;
			MODE_DRAW:   return MODE_HBLANK;
			MODE_HBLANK: return vbl ? MODE_VBLANK : MODE_OAM;
			default:     return MODE_OAM;
		endcase
	endfunction

	// --------------------
	// compare
	// --------------------
	always @(posedge clk) begin
		if (reset || !sh_lcdc[7]) begin
			trk_on = 0;
		end else begin
			// vsync marks dot 0 of line 0
			if (lcd_vsync && !vsync_q) begin
				if (trk_on) begin
					check_value("vsync_line", trk_line, 0);
					check_value("vsync_dot", trk_dot, 0);
				end
				trk_on = 1;
				trk_line = 0;
				trk_dot = 0;
				trk_pulses = 0;
			end
			if (trk_on) begin
				if (lcd_clkena) begin
					check_value("lcd_data", lcd_data, ref_pixel(trk_line, trk_pulses,
						sh_scx, sh_scy, sh_lcdc, sh_bgp, vram));
					trk_pulses++;
				end
				if (trk_dot == DOTS - 1) begin
					check_value("lcd_clkena_count", trk_pulses, trk_line < SCREEN_H ? SCREEN_W : 0);
					if (trk_line == SCREEN_H - 1)
						frames_done++;
					trk_pulses = 0;
					trk_dot = 0;
					trk_line = (trk_line == LINES - 1) ? 0 : trk_line + 1;
				end else begin
					trk_dot++;
				end
			end
		end
		vsync_q = lcd_vsync;
	end

	// --------------------
	// cpu side
	// --------------------
	task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
		@(negedge clk);
		cpu = '{sel: 1'b1, wr: 1'b1, addr: addr, di: data};
		@(negedge clk);
		cpu.wr = 1'b0;
		case (addr)
			REG_LCDC: sh_lcdc = data;
			REG_SCY:  sh_scy = data;
			REG_SCX:  sh_scx = data;
			REG_LYC:  sh_lyc = data;
			REG_BGP:  sh_bgp = data;
			default: ;
		endcase
	endtask

	task automatic set_addr(input logic [7:0] addr);
		@(negedge clk);
		cpu = '{sel: 1'b1, wr: 1'b0, addr: addr, di: 8'h00};
	endtask

	task automatic expect_reg(input logic [7:0] addr, input logic [7:0] exp);
		set_addr(addr);
		@(negedge clk);
		check_value($sformatf("cpu_do[%h]", addr), cpu_do, exp);
	endtask

	// lcd off, new scroll and palette, then lcdc last
	// tiles already fetched would otherwise use the old scroll
	task automatic set_config(input logic [7:0] lcdc);
		write_reg(REG_LCDC, 8'h00);
		write_reg(REG_SCY, 8'($urandom));
		write_reg(REG_SCX, 8'($urandom));
		write_reg(REG_BGP, 8'($urandom));
		write_reg(REG_LCDC, lcdc);
	endtask

	task automatic wait_frames(input int n);
		int target;
		target = frames_done + n;
		while (frames_done < target)
			@(negedge clk);
	endtask

	task automatic wait_line_start();
		@(negedge clk);
		while (!(trk_on == 1 && trk_dot == 0))
			@(negedge clk);
	endtask

	// per-cycle checks at the falling edge
	task automatic watch(input int kind, input int n);
		logic [1:0] mode;
		logic [1:0] prev;
		int draws;
		int hits;
		draws = 0;
		hits = 0;
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			mode = cpu_do[1:0];
			if (i == 0)
				prev = mode;
			case (kind)
				WATCH_MODE: begin
					check_value("stat_mode_vblank", mode == MODE_VBLANK, vblank_irq);
					if (trk_line < SCREEN_H && trk_dot < OAM_DOTS)
						check_value("stat_mode", mode, MODE_OAM);
					if (mode != prev) begin
						check_value("stat_mode", mode, next_mode(prev, vblank_irq));
						draws += int'(mode == MODE_DRAW);
					end
				end
				// latch settles a few dots into the line
				WATCH_LYC: if (trk_dot > 4) begin
					check_value("irq", irq, trk_line == int'(sh_lyc));
					check_value("stat_lyc", cpu_do[2], trk_line == int'(sh_lyc));
				end
				WATCH_VBL: begin
					check_value("lcd_on", lcd_on, 1'b1);
					check_value("irq", irq, trk_line >= SCREEN_H);
					check_value("vblank_irq", vblank_irq, trk_line >= SCREEN_H);
				end
				WATCH_HBL: begin
					hits += int'(irq);
					if (trk_dot == DOTS - 1) begin
						check_value("irq_per_line", hits, trk_line < SCREEN_H);
						hits = 0;
					end
				end
				default: begin
					check_value("lcd_on", lcd_on, 1'b0);
					check_value("ly", cpu_do, 8'h00);
					check_value("lcd_clkena", lcd_clkena, 1'b0);
					check_value("lcd_data", lcd_data, 2'b00);
					check_value("irq", irq, 1'b0);
				end
			endcase
			prev = mode;
		end
		if (kind == WATCH_MODE)
			check_value("mode3_lines", draws, SCREEN_H);
	endtask

	// --------------------
	// stimulus
	// --------------------
	initial begin
		logic [7:0] val;
		void'($urandom(82));
		cpu = '0;
		vram_data = 8'h00;
		sh_lcdc = 8'h00;
		sh_scy = 8'h00;
		sh_scx = 8'h00;
		sh_lyc = 8'h00;
		sh_bgp = 8'hfc;
		foreach (vram[a])
			vram[a] = 8'($urandom);
		reset = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// register read-back with the lcd still off
		expect_reg(REG_BGP, 8'hfc);
		val = 8'($urandom) & 8'h7f;
		write_reg(REG_LCDC, val);
		expect_reg(REG_LCDC, val);
		foreach (RW_REGS[i]) begin
			val = 8'($urandom);
			write_reg(RW_REGS[i], val);
			expect_reg(RW_REGS[i], val);
		end
		val = 8'($urandom);
		write_reg(REG_STAT, val);
		expect_reg(REG_STAT, {1'b1, val[6:3], 3'b000});
		expect_reg(8'h48, 8'hff);
		expect_reg(8'h4b, 8'hff);
		write_reg(REG_STAT, 8'h00);

		// signed tile data with map 0, then unsigned with map 1
		set_config(8'h81);
		wait_frames(1);
		set_config(8'h99);
		wait_frames(1);

		set_addr(REG_STAT);
		watch(WATCH_MODE, FRAME_CYCLES);

		write_reg(REG_LYC, 8'($urandom_range(SCREEN_H - 1)));
		write_reg(REG_STAT, 8'h40);
		wait_line_start();
		watch(WATCH_LYC, FRAME_CYCLES);
		write_reg(REG_STAT, 8'h10);
		wait_line_start();
		watch(WATCH_VBL, FRAME_CYCLES);
		write_reg(REG_STAT, 8'h08);
		wait_line_start();
		watch(WATCH_HBL, FRAME_CYCLES);

		// all sources enabled, lcd off
		write_reg(REG_STAT, 8'h78);
		write_reg(REG_LCDC, sh_lcdc & 8'h7f);
		set_addr(REG_LY);
		watch(WATCH_OFF, 4 * DOTS);
		write_reg(REG_STAT, 8'h00);
		set_config(8'h91);
		wait_frames(1);

		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- filelist.f
hw/ppu_pkg.sv
hw/ppu_reg_file.sv
hw/ppu_dot_timing.sv
hw/ppu_bg_fetcher.sv
hw/ppu_lcd_out.sv
hw/ppu_top.sv
sim/ppu_chk.sv
sim/ppu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the PPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module ppu_tb \
	-f filelist.f -o ppu_sim

# the simulation may stop on a failure, the log decides
./obj_dir/ppu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: PASSED" sim.log; then
	exit 0
else
	exit 1
fi
